//--- rtl/burst_decoder_config.svh
`ifndef BURST_DECODER_CONFIG_SVH
`define BURST_DECODER_CONFIG_SVH

// frame geometry.
`define NUM_CHANNELS 40
`define NUM_CHUNKS 5
`define ERROR_WIDTH 8

// samples consumed per trellis step.
`define BRANCH_LENGTH 2

// longest burst kept in the decision store.
`define TRACE_DEPTH 128

// trellis constants.
`define ERR_AMP 16
`define TRANS_PEN 8
`define METRIC_WIDTH 12

`endif

//--- rtl/burst_decoder_pkg.sv
`include "burst_decoder_config.svh"

package burst_decoder_pkg;

    typedef enum logic [2:0] {
        RESET,
        WAIT_FOR_EMPTY,
        INITIALIZE_VITERBI,
        RUN_VITERBI,
        GATHER_ADDITIONAL_FRAME,
        DONE
    } ctrl_state_t;

    typedef enum logic {
        IDLE,
        WALK
    } tb_state_t;

    // metrics are renormalized every sample, so they stay small.
    typedef logic [`METRIC_WIDTH-1:0] metric_t;

endpackage

//--- rtl/burst_decoder_top.sv
`timescale 1ns/100ps
`include "burst_decoder_config.svh"

module burst_decoder_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               push,
    input  logic signed [`ERROR_WIDTH-1:0]     in_errors [`NUM_CHANNELS-1:0],
    input  logic                               in_flags [`NUM_CHANNELS-1:0],
    input  logic [`NUM_CHUNKS-1:0]             in_coarse_flags,
    input  logic [$clog2(`NUM_CHUNKS)-1:0]     in_start_frame,
    output logic                               full,
    output logic                               result_valid,
    output logic [`TRACE_DEPTH-1:0]            result_bits,
    output logic [$clog2(`TRACE_DEPTH):0]      result_len,
    output logic                               busy
);
    import burst_decoder_pkg::*;

    logic signed [`ERROR_WIDTH-1:0] head_errors [`NUM_CHANNELS-1:0];
    logic                           head_flags [`NUM_CHANNELS-1:0];
    logic [`NUM_CHUNKS-1:0]         head_coarse;
    logic [$clog2(`NUM_CHUNKS)-1:0] head_start;
    logic                           fifo_empty, pop_n;
    logic signed [`ERROR_WIDTH-1:0] trace_vals [`BRANCH_LENGTH-1:0];
    logic                           run, initialize, frame_end;
    logic [$clog2(`TRACE_DEPTH)-1:0]  dec_addr;
    logic [1:0]                       dec_bits;
    logic [$clog2(`TRACE_DEPTH):0]    sample_count;
    metric_t                          final_metric_0, final_metric_1;

    err_frame_fifo u_fifo (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .push                     (push),
        .in_errors                (in_errors),
        .in_flags                 (in_flags),
        .in_coarse_flags          (in_coarse_flags),
        .in_start_frame           (in_start_frame),
        .pop_n                    (pop_n),
        .residual_estimated_error (head_errors),
        .flags                    (head_flags),
        .coarse_flags             (head_coarse),
        .start_frame              (head_start),
        .fifo_empty               (fifo_empty),
        .full                     (full)
    );

    viterbi_input_controller u_ctrl (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .residual_estimated_error (head_errors),
        .flags                    (head_flags),
        .start_frame              (head_start),
        .coarse_flags             (head_coarse),
        .fifo_empty               (fifo_empty),
        .pop_n                    (pop_n),
        .trace_vals               (trace_vals),
        .run                      (run),
        .initialize               (initialize),
        .frame_end                (frame_end),
        .idx                      ()
    );

    viterbi_acs u_acs (
        .clk            (clk),
        .rst_n          (rst_n),
        .initialize     (initialize),
        .run            (run),
        .trace_vals     (trace_vals),
        .dec_addr       (dec_addr),
        .dec_bits       (dec_bits),
        .sample_count   (sample_count),
        .final_metric_0 (final_metric_0),
        .final_metric_1 (final_metric_1)
    );

    viterbi_traceback u_tb (
        .clk            (clk),
        .rst_n          (rst_n),
        .frame_end      (frame_end),
        .pop_n          (pop_n),
        .sample_count   (sample_count),
        .final_metric_0 (final_metric_0),
        .final_metric_1 (final_metric_1),
        .dec_addr       (dec_addr),
        .dec_bits       (dec_bits),
        .result_valid   (result_valid),
        .result_bits    (result_bits),
        .result_len     (result_len),
        .busy           (busy)
    );

endmodule

//--- rtl/err_frame_fifo.sv
`timescale 1ns/100ps
`include "burst_decoder_config.svh"

module err_frame_fifo #(
    parameter int depth = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               push,
    input  logic signed [`ERROR_WIDTH-1:0]     in_errors [`NUM_CHANNELS-1:0],
    input  logic                               in_flags [`NUM_CHANNELS-1:0],
    input  logic [`NUM_CHUNKS-1:0]             in_coarse_flags,
    input  logic [$clog2(`NUM_CHUNKS)-1:0]     in_start_frame,
    input  logic                               pop_n,
    output logic signed [`ERROR_WIDTH-1:0]     residual_estimated_error [`NUM_CHANNELS-1:0],
    output logic                               flags [`NUM_CHANNELS-1:0],
    output logic [`NUM_CHUNKS-1:0]             coarse_flags,
    output logic [$clog2(`NUM_CHUNKS)-1:0]     start_frame,
    output logic                               fifo_empty,
    output logic                               full
);
    localparam int PW = $clog2(depth);

    logic signed [`ERROR_WIDTH-1:0] mem_err [depth-1:0][`NUM_CHANNELS-1:0];
    logic                           mem_flags [depth-1:0][`NUM_CHANNELS-1:0];
    logic [`NUM_CHUNKS-1:0]         mem_coarse [depth-1:0];
    logic [$clog2(`NUM_CHUNKS)-1:0] mem_start [depth-1:0];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [PW:0]   count;
    logic          do_push, do_pop;

    assign do_push = push && !full;
    assign do_pop  = !pop_n && !fifo_empty;
    assign fifo_empty = (count == '0);
    assign full       = (count == (PW+1)'(depth));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_err[wr_ptr]    <= in_errors;
            mem_flags[wr_ptr]  <= in_flags;
            mem_coarse[wr_ptr] <= in_coarse_flags;
            mem_start[wr_ptr]  <= in_start_frame;
        end
    end

    // head of queue, show-ahead.
    assign residual_estimated_error = mem_err[rd_ptr];
    assign flags        = mem_flags[rd_ptr];
    assign coarse_flags = mem_coarse[rd_ptr];
    assign start_frame  = mem_start[rd_ptr];

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(!pop_n && fifo_empty));

endmodule

//--- rtl/viterbi_acs.sv
`timescale 1ns/100ps
`include "burst_decoder_config.svh"

module viterbi_acs (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               initialize,
    input  logic                               run,
    input  logic signed [`ERROR_WIDTH-1:0]     trace_vals [`BRANCH_LENGTH-1:0],
    input  logic [$clog2(`TRACE_DEPTH)-1:0]    dec_addr,
    output logic [1:0]                         dec_bits,
    output logic [$clog2(`TRACE_DEPTH):0]      sample_count,
    output burst_decoder_pkg::metric_t         final_metric_0,
    output burst_decoder_pkg::metric_t         final_metric_1
);
    import burst_decoder_pkg::*;

    localparam int AW = $clog2(`TRACE_DEPTH);
    localparam metric_t PEN = metric_t'(`TRANS_PEN);

    metric_t    pm0, pm1;
    metric_t    m0_c [`BRANCH_LENGTH:0];
    metric_t    m1_c [`BRANCH_LENGTH:0];
    logic [1:0] dec_c [`BRANCH_LENGTH-1:0];
    logic [1:0] dec_mem [`TRACE_DEPTH-1:0];
    logic [AW:0] base;
    logic        step;

    assign step = initialize | run;
    assign base = initialize ? '0 : sample_count;

    // samples of one pair are processed in order.
    always_comb begin
        logic signed [`ERROR_WIDTH:0] xe, xd;
        logic [`ERROR_WIDTH:0] b0, b1;
        metric_t n0, n1, lo;
        logic from1, from0;
        m0_c[0] = initialize ? '0 : pm0;
        m1_c[0] = initialize ? PEN : pm1;
        for (int i = 0; i < `BRANCH_LENGTH; i++) begin
            xe = trace_vals[i];
            xd = xe - `ERR_AMP;
            b0 = xe[`ERROR_WIDTH] ? -xe : xe;
            b1 = xd[`ERROR_WIDTH] ? -xd : xd;
            from1 = (m1_c[i] + PEN) < m0_c[i]; // ties stay.
            from0 = (m0_c[i] + PEN) < m1_c[i];
            n0 = (from1 ? m1_c[i] + PEN : m0_c[i]) + metric_t'(b0);
            n1 = (from0 ? m0_c[i] + PEN : m1_c[i]) + metric_t'(b1);
            lo = (n1 < n0) ? n1 : n0;
            m0_c[i+1] = n0 - lo;
            m1_c[i+1] = n1 - lo;
            // bit s holds the predecessor of state s.
            dec_c[i] = {!from0, from1};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pm0          <= '0;
            pm1          <= '0;
            sample_count <= '0;
        end else if (step) begin
            pm0          <= m0_c[`BRANCH_LENGTH];
            pm1          <= m1_c[`BRANCH_LENGTH];
            sample_count <= base + (AW+1)'(`BRANCH_LENGTH);
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            for (int i = 0; i < `BRANCH_LENGTH; i++) begin
                dec_mem[AW'(base + i)] <= dec_c[i];
            end
        end
    end

    assign dec_bits       = dec_mem[dec_addr];
    assign final_metric_0 = pm0;
    assign final_metric_1 = pm1;

    // the controller must end a burst before the store runs out.
    a_store_depth: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> (sample_count <= `TRACE_DEPTH - `BRANCH_LENGTH));

endmodule

//--- rtl/viterbi_input_controller.sv
`timescale 1ns/100ps
`include "burst_decoder_config.svh"

module viterbi_input_controller (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic signed [`ERROR_WIDTH-1:0]     residual_estimated_error [`NUM_CHANNELS-1:0],
    input  logic                               flags [`NUM_CHANNELS-1:0],
    input  logic [$clog2(`NUM_CHUNKS)-1:0]     start_frame,
    input  logic [`NUM_CHUNKS-1:0]             coarse_flags,
    input  logic                               fifo_empty,
    output logic                               pop_n,
    output logic signed [`ERROR_WIDTH-1:0]     trace_vals [`BRANCH_LENGTH-1:0],
    output logic                               run,
    output logic                               initialize,
    output logic                               frame_end,
    output logic [$clog2(`NUM_CHANNELS)-1:0]   idx
);
    import burst_decoder_pkg::*;

    localparam int IDX_W     = $clog2(`NUM_CHANNELS);
    localparam int LAST_PAIR = `NUM_CHANNELS - `BRANCH_LENGTH;

    ctrl_state_t state, next_state;

    logic signed [`ERROR_WIDTH-1:0] cur_frame [`NUM_CHANNELS-1:0];
    logic                           cur_flags [`NUM_CHANNELS-1:0];
    logic [`NUM_CHUNKS-1:0]         cur_coarse;
    logic [2*`NUM_CHUNKS-1:0]       coarse_window;
    logic [IDX_W-1:0]               next_idx, start_pos;
    logic [IDX_W-4:0]               chunk;
    logic [3:0]                     zero_count, next_zero_count;
    logic count_zeros, next_count_zeros;
    logic continuation, pair_flagged, last_pair, load_frame, gather_pop;

    // highest flag in the start chunk, rounded down to a pair boundary.
    always_comb begin
        start_pos = '0;
        for (int k = 0; k < 8; k++) begin
            if (flags[start_frame * 8 + k]) begin
                start_pos = IDX_W'(start_frame * 8 + (k & ~1));
            end
        end
    end

    always_comb begin
        pair_flagged = 1'b0;
        for (int i = 0; i < `BRANCH_LENGTH; i++) begin
            pair_flagged = pair_flagged | cur_flags[idx + i];
        end
    end

    // chunks beyond this frame come from the queued frame, if any.
    assign coarse_window = {(fifo_empty ? '0 : coarse_flags), cur_coarse};
    assign chunk         = idx[IDX_W-1:3];
    assign continuation  = coarse_window[chunk + 1] | coarse_window[chunk + 2];
    assign last_pair     = (idx >= IDX_W'(LAST_PAIR));
    assign gather_pop    = (state == GATHER_ADDITIONAL_FRAME) && !fifo_empty;
    assign load_frame    = gather_pop || ((state == WAIT_FOR_EMPTY) && !fifo_empty);

    always_comb begin
        next_state       = state;
        next_idx         = idx;
        next_zero_count  = zero_count;
        next_count_zeros = count_zeros;
        case (state)
            RESET: begin
                next_state = WAIT_FOR_EMPTY;
            end
            WAIT_FOR_EMPTY: begin
                next_zero_count  = '0;
                next_count_zeros = 1'b0;
                if (!fifo_empty) begin
                    next_state = INITIALIZE_VITERBI;
                    next_idx   = start_pos;
                end
            end
            INITIALIZE_VITERBI, RUN_VITERBI: begin
                next_count_zeros = count_zeros | !continuation; // sticky.
                next_zero_count  = (count_zeros && !pair_flagged) ? zero_count + 4'd1 : '0;
                if (next_zero_count == 4'd8) begin
                    next_state = DONE;
                end else if (last_pair) begin
                    next_state = GATHER_ADDITIONAL_FRAME;
                    next_idx   = '0;
                end else begin
                    next_state = RUN_VITERBI;
                    next_idx   = idx + IDX_W'(`BRANCH_LENGTH);
                end
            end
            GATHER_ADDITIONAL_FRAME: begin
                if (!fifo_empty) next_state = RUN_VITERBI;
            end
            DONE: begin
                next_state = WAIT_FOR_EMPTY;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= RESET;
            idx         <= '0;
            zero_count  <= '0;
            count_zeros <= 1'b0;
            cur_coarse  <= '0;
        end else begin
            state       <= next_state;
            idx         <= next_idx;
            zero_count  <= next_zero_count;
            count_zeros <= next_count_zeros;
            if (load_frame) cur_coarse <= coarse_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (load_frame) begin
            cur_frame <= residual_estimated_error;
            cur_flags <= flags;
        end
    end

    assign run        = (state == RUN_VITERBI);
    assign initialize = (state == INITIALIZE_VITERBI);
    assign pop_n      = !(initialize || gather_pop); // first frame leaves during init.
    assign frame_end  = !((state == DONE) || gather_pop);

    always_comb begin
        for (int i = 0; i < `BRANCH_LENGTH; i++) begin
            trace_vals[i] = (run || initialize) ? cur_frame[idx + i] : '0;
        end
    end

    a_chunk_geometry: assert property (@(posedge clk) `NUM_CHANNELS == 8 * `NUM_CHUNKS);
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        (run || initialize) |-> (idx + `BRANCH_LENGTH <= `NUM_CHANNELS));

endmodule

//--- rtl/viterbi_traceback.sv
`timescale 1ns/100ps
`include "burst_decoder_config.svh"

module viterbi_traceback (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               frame_end,
    input  logic                               pop_n,
    input  logic [$clog2(`TRACE_DEPTH):0]      sample_count,
    input  burst_decoder_pkg::metric_t         final_metric_0,
    input  burst_decoder_pkg::metric_t         final_metric_1,
    output logic [$clog2(`TRACE_DEPTH)-1:0]    dec_addr,
    input  logic [1:0]                         dec_bits,
    output logic                               result_valid,
    output logic [`TRACE_DEPTH-1:0]            result_bits,
    output logic [$clog2(`TRACE_DEPTH):0]      result_len,
    output logic                               busy
);
    import burst_decoder_pkg::*;

    localparam int AW = $clog2(`TRACE_DEPTH);

    tb_state_t   state;
    logic [AW-1:0] pos;
    logic          cur, start;

    assign start = !frame_end && pop_n; // only true in DONE.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            pos          <= '0;
            cur          <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= WALK;
                        pos   <= AW'(sample_count - 1'b1);
                        cur   <= (final_metric_1 < final_metric_0);
                    end
                end
                WALK: begin
                    cur <= dec_bits[cur];
                    pos <= pos - 1'b1;
                    if (pos == '0) begin
                        state        <= IDLE;
                        result_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            result_bits <= '0;
            result_len  <= sample_count;
        end else if (state == WALK) begin
            result_bits[pos] <= cur;
        end
    end

    assign dec_addr = pos;
    assign busy     = (state == WALK);

endmodule

//--- src.f
+incdir+rtl
rtl/burst_decoder_pkg.sv
rtl/err_frame_fifo.sv
rtl/viterbi_input_controller.sv
rtl/viterbi_acs.sv
rtl/viterbi_traceback.sv
rtl/burst_decoder_top.sv
verif/tb_burst_decoder.sv

//--- verif/tb_burst_decoder.sv
`timescale 1ns/100ps
`include "burst_decoder_config.svh"

module tb_burst_decoder;
    import burst_decoder_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000; // nine bursts of at most 128 samples, with wide margin.
    localparam int LATE_GAP       = 30;

    logic clk = 1'b0;
    logic rst_n;
    logic push;
    logic signed [`ERROR_WIDTH-1:0] in_errors [`NUM_CHANNELS-1:0];
    logic in_flags [`NUM_CHANNELS-1:0];
    logic [`NUM_CHUNKS-1:0] in_coarse_flags;
    logic [$clog2(`NUM_CHUNKS)-1:0] in_start_frame;
    logic full, result_valid, busy;
    logic [`TRACE_DEPTH-1:0] result_bits;
    logic [$clog2(`TRACE_DEPTH):0] result_len;

    // frames of the burst being built.
    logic signed [`ERROR_WIDTH-1:0] fr_err [0:2][`NUM_CHANNELS-1:0];
    logic fr_flag [0:2][`NUM_CHANNELS-1:0];
    logic [`NUM_CHUNKS-1:0] fr_coarse [0:2];
    int fr_start [0:2];

    logic [`TRACE_DEPTH-1:0] exp_bits_q [$];
    int exp_len_q [$];
    int errors = 0;
    int n_issued = 0;
    int n_results = 0;
    int cycles = 0;
    int busy_cycles = 0;
    integer seed = 35932;
    ctrl_state_t st_snap;

    burst_decoder_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .push            (push),
        .in_errors       (in_errors),
        .in_flags        (in_flags),
        .in_coarse_flags (in_coarse_flags),
        .in_start_frame  (in_start_frame),
        .full            (full),
        .result_valid    (result_valid),
        .result_bits     (result_bits),
        .result_len      (result_len),
        .busy            (busy)
    );

    always #5 clk = ~clk;

    // expected bitmap and length of one burst; late means frame 1 arrives after frame 0 ran out.
    function automatic void expect_burst(input int nfr, input bit late,
                                         output logic [`TRACE_DEPTH-1:0] bits, output int len);
        int f, idx, cz, zc, ncz, nzc, chunk, s, x, m0, m1, n0, n1, b0, b1, lo;
        logic [2*`NUM_CHUNKS-1:0] win;
        logic [`NUM_CHUNKS-1:0] head;
        bit cont, pf, done, first, from0, from1, cur;
        bit pred0 [0:`TRACE_DEPTH-1];
        bit pred1 [0:`TRACE_DEPTH-1];
        int xs [$];
        f = 0;
        idx = 0;
        cz = 0;
        zc = 0;
        done = 0;
        first = 1;
        for (int k = 0; k < 8; k++) begin
            if (fr_flag[0][fr_start[0] * 8 + k]) idx = fr_start[0] * 8 + (k / 2) * 2;
        end
        while (!done) begin
            // the head of the queue is the frame itself until the first pop.
            if (first) head = fr_coarse[0];
            else if (f + 1 < nfr && !(late && f == 0)) head = fr_coarse[f + 1];
            else head = '0;
            win = {head, fr_coarse[f]};
            chunk = idx / 8;
            cont = win[chunk + 1] | win[chunk + 2];
            pf = fr_flag[f][idx] | fr_flag[f][idx + 1];
            xs.push_back(fr_err[f][idx]);
            xs.push_back(fr_err[f][idx + 1]);
            ncz = cz | !cont;
            nzc = (cz && !pf) ? zc + 1 : 0;
            if (nzc == 8) begin
                done = 1;
            end else if (idx >= `NUM_CHANNELS - 2) begin
                f++;
                idx = 0;
                if (f >= nfr) begin
                    errors++;
                    $display("burst model ran past the last frame pushed");
                    done = 1;
                end
            end else begin
                idx += 2;
            end
            cz = ncz;
            zc = nzc;
            first = 0;
        end
        len = xs.size();
        m0 = 0;
        m1 = `TRANS_PEN;
        for (s = 0; s < len; s++) begin
            x = xs[s];
            b0 = (x < 0) ? -x : x;
            b1 = (x - `ERR_AMP < 0) ? `ERR_AMP - x : x - `ERR_AMP;
            from1 = (m1 + `TRANS_PEN) < m0;
            from0 = (m0 + `TRANS_PEN) < m1;
            n0 = (from1 ? m1 + `TRANS_PEN : m0) + b0;
            n1 = (from0 ? m0 + `TRANS_PEN : m1) + b1;
            pred0[s] = from1;
            pred1[s] = !from0;
            lo = (n1 < n0) ? n1 : n0;
            m0 = n0 - lo;
            m1 = n1 - lo;
        end
        bits = '0;
        cur = (m1 < m0);
        for (s = len - 1; s >= 0; s--) begin
            bits[s] = cur;
            cur = cur ? pred1[s] : pred0[s];
        end
    endfunction

    task automatic clear_frames();
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                fr_err[k][i] = '0;
                fr_flag[k][i] = 1'b0;
            end
            fr_coarse[k] = '0;
            fr_start[k] = 0;
        end
    endtask

    task automatic push_frame(input int k);
        @(posedge clk);
        if (full) begin
            errors++;
            $display("frame FIFO full when frame %0d was pushed at %0t", k, $time);
        end
        push <= 1'b1;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            in_errors[i] <= fr_err[k][i];
            in_flags[i]  <= fr_flag[k][i];
        end
        in_coarse_flags <= fr_coarse[k];
        in_start_frame  <= fr_start[k][2:0];
    endtask

    task automatic end_push();
        @(posedge clk);
        push <= 1'b0;
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            if (result_valid !== 1'b0) begin
                errors++;
                $display("FAIL %0t result_valid: got %b expected 0", $time, result_valid);
            end
            if (busy !== 1'b0) begin
                errors++;
                $display("FAIL %0t busy: got %b expected 0", $time, busy);
            end
        end
    endtask

    task automatic run_burst(input int nfr, input bit late);
        logic [`TRACE_DEPTH-1:0] eb;
        int el;
        expect_burst(nfr, late, eb, el);
        exp_bits_q.push_back(eb);
        exp_len_q.push_back(el);
        n_issued++;
        for (int k = 0; k < nfr; k++) begin
            if (k == 1 && late) begin
                end_push();
                repeat (LATE_GAP) @(posedge clk);
            end
            push_frame(k);
        end
        end_push();
        while (n_results < n_issued) @(posedge clk);
        check_idle(8);
    endtask

    always @(posedge clk) begin
        logic [`TRACE_DEPTH-1:0] eb;
        int el;
        if (rst_n && busy === 1'b1) busy_cycles = busy_cycles + 1; // one sample per walk cycle.
        if (rst_n && result_valid) begin
            if (exp_bits_q.size() == 0) begin
                errors++;
                $display("result_valid pulsed at %0t with no burst pending", $time);
            end else begin
                eb = exp_bits_q.pop_front();
                el = exp_len_q.pop_front();
                if (result_len !== el) begin
                    errors++;
                    $display("FAIL %0t result_len: got %0d expected %0d", $time, result_len, el);
                end
                if (result_bits !== eb) begin
                    errors++;
                    $display("FAIL %0t result_bits: got %h expected %h", $time, result_bits, eb);
                end
                if (busy_cycles != el) begin
                    errors++;
                    $display("FAIL %0t busy: high for %0d cycles expected %0d",
                             $time, busy_cycles, el);
                end
                n_results <= n_results + 1;
            end
            busy_cycles = 0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            st_snap = u_dut.u_ctrl.state;
            $display("timeout after %0d cycles, controller in %s, %0d of %0d results seen",
                     cycles, st_snap.name(), n_results, n_issued);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int c, v;
        rst_n = 1'b0;
        push = 1'b0;
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            in_errors[i] = '0;
            in_flags[i] = 1'b0;
        end
        in_coarse_flags = '0;
        in_start_frame = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(4);

        // burst in chunk 1, highest flag 13 gives start 12.
        clear_frames();
        fr_start[0] = 1;
        fr_coarse[0] = 5'b00010;
        for (int i = 11; i <= 13; i++) begin
            fr_err[0][i] = `ERR_AMP;
            fr_flag[0][i] = 1'b1;
        end
        run_burst(1, 0);

        // start chunk without flags.
        clear_frames();
        fr_start[0] = 2;
        fr_err[0][3] = `ERR_AMP;
        fr_flag[0][3] = 1'b1;
        run_burst(1, 0);

        // continuation past the frame end, second frame arrives late.
        clear_frames();
        fr_start[0] = 3;
        fr_coarse[0] = 5'b11000;
        for (int i = 29; i < `NUM_CHANNELS; i++) begin
            fr_err[0][i] = `ERR_AMP;
            fr_flag[0][i] = 1'b1;
        end
        for (int i = 0; i < 3; i++) begin
            fr_err[1][i] = `ERR_AMP;
            fr_flag[1][i] = 1'b1;
        end
        run_burst(2, 1);

        // noisy random bursts.
        for (int b = 0; b < 6; b++) begin
            clear_frames();
            fr_start[0] = {$random(seed)} % 3;
            fr_coarse[0] = 5'b00001 << fr_start[0];
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                c = {$random(seed)} % 3;
                v = (c == 0) ? 0 : ((c == 1) ? `ERR_AMP : -`ERR_AMP);
                v = v + $random(seed) % 4;
                fr_err[0][i] = 8'(v);
                fr_flag[0][i] = (i / 8 == fr_start[0]) && (c == 1);
            end
            run_burst(1, 0);
        end

        $display("errors: %0d, results: %0d of %0d bursts", errors, n_results, n_issued);
        if (errors == 0 && n_results == n_issued) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
